//--- build.f
breakoutPkg.sv
brickTable.sv
paddleTracker.sv
rectFill.sv
drawSequencer.sv
breakoutDatapath.sv
breakoutTb_properties.sv
breakoutTb.sv

//--- run.sh
#!/usr/bin/env bash
# compiles the breakout datapath testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module breakoutTb -f build.f -o breakoutSim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/breakoutSim > sim.log 2>&1
simStatus=$?
cat sim.log

if [ $simStatus -eq 0 ] && grep -qx "Simulation passed" sim.log; then
    echo "PASS"
    exit 0
fi
echo "FAIL: simulation exit status $simStatus"
exit 1

//--- breakoutTb.sv
`timescale 1ns/1ps
`default_nettype none

module breakoutTb;

    localparam int ClkPeriod = 40;
    localparam int DriveDelay = 2;
    localparam int ResetCycles = 16;
    // four brick passes of 120x40 and 43 paddle commands of two 80x20 passes each
    localparam int TotalPixels = 4 * 4800 + 43 * 3200;
    // pixReady is high about 3/4 of the time, so two cycles per pixel leaves room
    localparam int CycleLimit = 2 * TotalPixels + 20000;
    localparam int ColourRef [12] = '{4, 5, 4, 2, 2, 4, 1, 4, 5, 5, 3, 5};

    logic clk;
    logic ld_resetInitial;
    logic cmdValid;
    breakoutPkg::opcode_t cmdOp;
    logic [breakoutPkg::BrickIdxW-1:0] cmdBrick;
    logic left;
    logic right;
    logic pixReady;
    logic cmdReady;
    logic pixValid;
    logic [breakoutPkg::XW-1:0] pixX;
    logic [breakoutPkg::YW-1:0] pixY;
    logic [breakoutPkg::ColourW-1:0] pixColour;
    logic [breakoutPkg::NumBricks-1:0] brickAlive;

    integer seed = 24;
    int cycleCount = 0;
    logic [11:0] aliveModel = 12'hfff;
    int paddleModel = 280;
    int oldPaddleModel = 280;
    breakoutPkg::opcode_t snapOp;
    int snapBrick;
    int snapOldX;
    int snapNewX;
    int snapCount = 0;
    int pixCount = 0;
    logic [21:0] expPix;

    breakoutDatapath breakoutDatapath_inst (
        .clk(clk),
        .ld_resetInitial(ld_resetInitial),
        .cmdValid(cmdValid),
        .cmdOp(cmdOp),
        .cmdBrick(cmdBrick),
        .left(left),
        .right(right),
        .pixReady(pixReady),
        .cmdReady(cmdReady),
        .pixValid(pixValid),
        .pixX(pixX),
        .pixY(pixY),
        .pixColour(pixColour),
        .brickAlive(brickAlive)
    );

    task automatic checkValue(
        input string name,
        input logic [31:0] actual,
        input logic [31:0] expected
    );
        if (actual !== expected)
        begin
            $display("FAIL %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    // pixel k of the command in flight, packed as {x, y, colour}
    function automatic logic [21:0] expectedPixel(input int k);
        int ox;
        int oy;
        int w;
        int colour;
        int idx;
        idx = k;
        if ((snapOp == breakoutPkg::opMovePaddle) || (snapOp == breakoutPkg::opRedrawPaddle))
        begin
            // 1600 erase pixels at the old X come before the draw at the new X
            w = 80;
            oy = 440;
            ox = (k < 1600) ? snapOldX : snapNewX;
            colour = (k < 1600) ? 0 : 7;
            idx = (k < 1600) ? k : k - 1600;
        end
        else
        begin
            w = 120;
            ox = 20 + 140 * (snapBrick % 4);
            oy = 20 + 60 * (snapBrick / 4);
            colour = (snapOp == breakoutPkg::opRemove) ? 0 : ColourRef[snapBrick];
        end
        return {10'(ox + idx % w), 9'(oy + idx / w), 3'(colour)};
    endfunction

    task automatic runCommand(
        input breakoutPkg::opcode_t op,
        input int brick,
        input logic l,
        input logic r
    );
        @(negedge clk);
        while (!cmdReady)
        begin
            @(negedge clk);
        end
        snapOp = op;
        snapBrick = brick;
        pixCount = 0;
        snapCount = 3200;
        if (op == breakoutPkg::opPopulate)
        begin
            snapCount = aliveModel[brick] ? 4800 : 0;
        end
        else if (op == breakoutPkg::opRemove)
        begin
            snapCount = 4800;
            aliveModel[brick] = 1'b0;
        end
        else if (op == breakoutPkg::opMovePaddle)
        begin
            oldPaddleModel = paddleModel;
            if (l && !r)
            begin
                paddleModel = paddleModel - 8;
            end
            if (r && !l)
            begin
                paddleModel = paddleModel + 8;
            end
            paddleModel = (paddleModel < 0) ? 0 : paddleModel;
            paddleModel = (paddleModel > 560) ? 560 : paddleModel;
        end
        snapOldX = oldPaddleModel;
        snapNewX = paddleModel;
        @(posedge clk);
        #DriveDelay;
        cmdValid = 1'b1;
        cmdOp = op;
        cmdBrick = 4'(brick);
        left = l;
        right = r;
        // cmdReady is already high, so the next edge takes the command
        @(posedge clk);
        #DriveDelay;
        cmdValid = 1'b0;
        @(negedge clk);
        while (!cmdReady)
        begin
            @(negedge clk);
        end
        checkValue("pixel count", 32'(pixCount), 32'(snapCount));
        checkValue("brickAlive", 32'(brickAlive), 32'(aliveModel));
    endtask

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(ClkPeriod / 2) clk = ~clk;
        end
    end

    initial
    begin
        pixReady = 1'b0;
        forever
        begin
            @(posedge clk);
            #DriveDelay;
            pixReady = ($random(seed) & 3) != 0;
        end
    end

    // a transfer seen here lands on the next rising edge
    always @(negedge clk)
    begin
        if (!ld_resetInitial && pixValid && pixReady)
        begin
            if (pixCount >= snapCount)
            begin
                $display("unexpected pixel at x %0d y %0d after %0d expected pixels",
                         pixX, pixY, snapCount);
                $display("Simulation failed");
                $fatal(1);
            end
            else
            begin
                expPix = expectedPixel(pixCount);
                checkValue("pixX", 32'(pixX), 32'(expPix[21:12]));
                checkValue("pixY", 32'(pixY), 32'(expPix[11:3]));
                checkValue("pixColour", 32'(pixColour), 32'(expPix[2:0]));
                pixCount = pixCount + 1;
            end
        end
    end

    always @(posedge clk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CycleLimit)
        begin
            $display("timeout: the command sequence did not finish in %0d cycles", CycleLimit);
            $display("Simulation failed");
            $fatal(1);
        end
    end

    initial
    begin
        ld_resetInitial = 1'b1;
        cmdValid = 1'b0;
        cmdOp = breakoutPkg::opPopulate;
        cmdBrick = '0;
        left = 1'b0;
        right = 1'b0;
        repeat (ResetCycles) @(posedge clk);
        #DriveDelay;
        ld_resetInitial = 1'b0;
        checkValue("brickAlive", 32'(brickAlive), 32'hfff);
        runCommand(breakoutPkg::opPopulate, 0, 1'b0, 1'b0);
        runCommand(breakoutPkg::opPopulate, 6, 1'b0, 1'b0);
        runCommand(breakoutPkg::opPopulate, 11, 1'b0, 1'b0);
        runCommand(breakoutPkg::opRemove, 6, 1'b0, 1'b0);
        checkValue("brickAlive[6]", 32'(brickAlive[6]), 32'(0));
        // brick 6 is dead now, so nothing is drawn
        runCommand(breakoutPkg::opPopulate, 6, 1'b0, 1'b0);
        runCommand(breakoutPkg::opRedrawPaddle, 0, 1'b0, 1'b0);
        runCommand(breakoutPkg::opMovePaddle, 0, 1'b0, 1'b1);
        // away from the edges and with old and new X apart, a hold is visible in both passes
        runCommand(breakoutPkg::opMovePaddle, 0, 1'b1, 1'b1);
        repeat (40) runCommand(breakoutPkg::opMovePaddle, 0, 1'b1, 1'b0);
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- breakoutTb_properties.sv
`timescale 1ns/1ps
`default_nettype none

module breakoutTb_properties (
    input wire logic clk,
    input wire logic ld_resetInitial,
    input wire logic cmdReady,
    input wire logic pixValid,
    input wire logic pixReady,
    input wire logic [breakoutPkg::XW-1:0] pixX,
    input wire logic [breakoutPkg::YW-1:0] pixY,
    input wire logic [breakoutPkg::ColourW-1:0] pixColour
);

    // a stalled pixel stays on offer unchanged
    stallHolds: assert property (@(posedge clk) disable iff (ld_resetInitial)
        pixValid && !pixReady |=> pixValid && $stable({pixX, pixY, pixColour}))
        else $error("stalled pixel was dropped or changed");

    // the command stays open while a pixel is on offer and for the cycle after it
    noCmdWhileDrawing: assert property (@(posedge clk) disable iff (ld_resetInitial)
        pixValid |-> !cmdReady ##1 !cmdReady)
        else $error("cmdReady high while a pixel is pending or right after it");

    readyAfterReset: assert property (@(posedge clk)
        $fell(ld_resetInitial) |-> cmdReady)
        else $error("cmdReady low in the first cycle after reset");

endmodule

bind breakoutDatapath breakoutTb_properties breakoutTb_properties_inst (
    .clk(clk),
    .ld_resetInitial(ld_resetInitial),
    .cmdReady(cmdReady),
    .pixValid(pixValid),
    .pixReady(pixReady),
    .pixX(pixX),
    .pixY(pixY),
    .pixColour(pixColour)
);

`default_nettype wire

//--- breakoutDatapath.sv
`timescale 1ns/1ps
`default_nettype none

module breakoutDatapath (
    input wire logic clk,
    input wire logic ld_resetInitial,
    input wire logic cmdValid,
    input wire breakoutPkg::opcode_t cmdOp,
    input wire logic [breakoutPkg::BrickIdxW-1:0] cmdBrick,
    input wire logic left,
    input wire logic right,
    input wire logic pixReady,
    output logic cmdReady,
    output logic pixValid,
    output logic [breakoutPkg::XW-1:0] pixX,
    output logic [breakoutPkg::YW-1:0] pixY,
    output logic [breakoutPkg::ColourW-1:0] pixColour,
    output logic [breakoutPkg::NumBricks-1:0] brickAlive
);

    logic [breakoutPkg::BrickIdxW-1:0] brickIdx;
    logic brickClear;
    logic [breakoutPkg::XW-1:0] brickOriginX;
    logic [breakoutPkg::YW-1:0] brickOriginY;
    logic [breakoutPkg::ColourW-1:0] brickColour;
    logic paddleMove;
    logic [breakoutPkg::XW-1:0] paddleX;
    logic [breakoutPkg::XW-1:0] oldPaddleX;
    logic rectValid;
    logic rectReady;
    logic [breakoutPkg::XW-1:0] rectX;
    logic [breakoutPkg::YW-1:0] rectY;
    logic [breakoutPkg::XW-1:0] rectW;
    logic [breakoutPkg::YW-1:0] rectH;
    logic [breakoutPkg::ColourW-1:0] rectColour;

    drawSequencer drawSequencer_inst (
        .clk(clk),
        .ld_resetInitial(ld_resetInitial),
        .cmdValid(cmdValid),
        .cmdOp(cmdOp),
        .cmdBrick(cmdBrick),
        .brickOriginX(brickOriginX),
        .brickOriginY(brickOriginY),
        .brickColour(brickColour),
        .brickAlive(brickAlive),
        .paddleX(paddleX),
        .oldPaddleX(oldPaddleX),
        .rectReady(rectReady),
        .cmdReady(cmdReady),
        .brickIdx(brickIdx),
        .brickClear(brickClear),
        .paddleMove(paddleMove),
        .rectValid(rectValid),
        .rectX(rectX),
        .rectY(rectY),
        .rectW(rectW),
        .rectH(rectH),
        .rectColour(rectColour)
    );

    brickTable brickTable_inst (
        .clk(clk),
        .ld_resetInitial(ld_resetInitial),
        .brickClear(brickClear),
        .brickIdx(brickIdx),
        .brickOriginX(brickOriginX),
        .brickOriginY(brickOriginY),
        .brickColour(brickColour),
        .brickAlive(brickAlive)
    );

    paddleTracker paddleTracker_inst (
        .clk(clk),
        .ld_resetInitial(ld_resetInitial),
        .paddleMove(paddleMove),
        .left(left),
        .right(right),
        .paddleX(paddleX),
        .oldPaddleX(oldPaddleX)
    );

    rectFill rectFill_inst (
        .clk(clk),
        .ld_resetInitial(ld_resetInitial),
        .rectValid(rectValid),
        .rectX(rectX),
        .rectY(rectY),
        .rectW(rectW),
        .rectH(rectH),
        .rectColour(rectColour),
        .pixReady(pixReady),
        .rectReady(rectReady),
        .pixValid(pixValid),
        .pixX(pixX),
        .pixY(pixY),
        .pixColour(pixColour)
    );

endmodule

`default_nettype wire

//--- drawSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module drawSequencer (
    input wire logic clk,
    input wire logic ld_resetInitial,
    input wire logic cmdValid,
    input wire breakoutPkg::opcode_t cmdOp,
    input wire logic [breakoutPkg::BrickIdxW-1:0] cmdBrick,
    input wire logic [breakoutPkg::XW-1:0] brickOriginX,
    input wire logic [breakoutPkg::YW-1:0] brickOriginY,
    input wire logic [breakoutPkg::ColourW-1:0] brickColour,
    input wire logic [breakoutPkg::NumBricks-1:0] brickAlive,
    input wire logic [breakoutPkg::XW-1:0] paddleX,
    input wire logic [breakoutPkg::XW-1:0] oldPaddleX,
    input wire logic rectReady,
    output logic cmdReady,
    output logic [breakoutPkg::BrickIdxW-1:0] brickIdx,
    output logic brickClear,
    output logic paddleMove,
    output logic rectValid,
    output logic [breakoutPkg::XW-1:0] rectX,
    output logic [breakoutPkg::YW-1:0] rectY,
    output logic [breakoutPkg::XW-1:0] rectW,
    output logic [breakoutPkg::YW-1:0] rectH,
    output logic [breakoutPkg::ColourW-1:0] rectColour
);

    typedef enum logic [1:0] {
        sIdle,
        sDecode,
        sIssue,
        sWait
    } state_t;

    state_t state;
    breakoutPkg::opcode_t opReg;
    logic [breakoutPkg::BrickIdxW-1:0] brickReg;
    logic drawPending;
    logic accept;
    logic skipDraw;
    logic isPaddleOp;

    assign cmdReady = (state == sIdle) && rectReady;
    assign accept = cmdValid && cmdReady;

    // the clear and the move land on the accepting edge, so the table looks at cmdBrick then
    assign brickIdx = (state == sIdle) ? cmdBrick : brickReg;
    assign brickClear = accept && (cmdOp == breakoutPkg::opRemove);
    assign paddleMove = accept && (cmdOp == breakoutPkg::opMovePaddle);
    assign rectValid = (state == sIssue);

    assign isPaddleOp = (opReg == breakoutPkg::opMovePaddle) ||
                        (opReg == breakoutPkg::opRedrawPaddle);
    assign skipDraw = (opReg == breakoutPkg::opPopulate) &&
                      ((brickReg >= breakoutPkg::NumBricks) || !brickAlive[brickReg]);

    always_ff @(posedge clk)
    begin
        if (ld_resetInitial)
        begin
            state <= sIdle;
            drawPending <= 1'b0;
        end
        else
        begin
            case (state)
                sIdle:
                begin
                    if (accept)
                    begin
                        state <= sDecode;
                    end
                end
                sDecode:
                begin
                    state <= skipDraw ? sIdle : sIssue;
                    drawPending <= isPaddleOp;
                end
                sIssue:
                begin
                    if (rectReady)
                    begin
                        state <= sWait;
                    end
                end
                default:
                begin
                    // rectReady comes back once the last pixel of the pass is taken
                    if (rectReady)
                    begin
                        state <= drawPending ? sIssue : sIdle;
                        drawPending <= 1'b0;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            opReg <= cmdOp;
            brickReg <= cmdBrick;
        end
        if (state == sDecode)
        begin
            if (isPaddleOp)
            begin
                // paddle commands start with the erase pass
                rectX <= oldPaddleX;
                rectY <= breakoutPkg::PaddleY;
                rectW <= breakoutPkg::PaddleW;
                rectH <= breakoutPkg::PaddleH;
                rectColour <= breakoutPkg::ColourBlack;
            end
            else
            begin
                rectX <= brickOriginX;
                rectY <= brickOriginY;
                rectW <= breakoutPkg::BrickW;
                rectH <= breakoutPkg::BrickH;
                if (opReg == breakoutPkg::opRemove)
                begin
                    rectColour <= breakoutPkg::ColourBlack;
                end
                else
                begin
                    rectColour <= brickColour;
                end
            end
        end
        else if ((state == sWait) && rectReady && drawPending)
        begin
            rectX <= paddleX;
            rectColour <= breakoutPkg::ColourPaddle;
        end
    end

endmodule

`default_nettype wire

//--- rectFill.sv
`timescale 1ns/1ps
`default_nettype none

module rectFill (
    input wire logic clk,
    input wire logic ld_resetInitial,
    input wire logic rectValid,
    input wire logic [breakoutPkg::XW-1:0] rectX,
    input wire logic [breakoutPkg::YW-1:0] rectY,
    input wire logic [breakoutPkg::XW-1:0] rectW,
    input wire logic [breakoutPkg::YW-1:0] rectH,
    input wire logic [breakoutPkg::ColourW-1:0] rectColour,
    input wire logic pixReady,
    output logic rectReady,
    output logic pixValid,
    output logic [breakoutPkg::XW-1:0] pixX,
    output logic [breakoutPkg::YW-1:0] pixY,
    output logic [breakoutPkg::ColourW-1:0] pixColour
);

    logic busy;
    logic rectTake;
    logic pixTake;
    logic lastCol;
    logic lastRow;
    logic [breakoutPkg::XW-1:0] xOrg;
    logic [breakoutPkg::XW-1:0] xEnd;
    logic [breakoutPkg::YW-1:0] yEnd;

    assign rectReady = !busy;
    assign pixValid = busy;
    assign rectTake = rectValid && rectReady;
    assign pixTake = busy && pixReady;
    assign lastCol = (pixX == xEnd);
    assign lastRow = (pixY == yEnd);

    always_ff @(posedge clk)
    begin
        if (ld_resetInitial)
        begin
            busy <= 1'b0;
        end
        else if (rectTake)
        begin
            busy <= 1'b1;
        end
        else if (pixTake && lastCol && lastRow)
        begin
            busy <= 1'b0;
        end
    end

    // pixX and pixY are the pixel on offer and only move once it is taken
    always_ff @(posedge clk)
    begin
        if (rectTake)
        begin
            xOrg <= rectX;
            xEnd <= rectX + rectW - 1'b1;
            yEnd <= rectY + rectH - 1'b1;
            pixX <= rectX;
            pixY <= rectY;
            pixColour <= rectColour;
        end
        else if (pixTake)
        begin
            if (lastCol)
            begin
                pixX <= xOrg;
                pixY <= pixY + 1'b1;
            end
            else
            begin
                pixX <= pixX + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- paddleTracker.sv
`timescale 1ns/1ps
`default_nettype none

module paddleTracker (
    input wire logic clk,
    input wire logic ld_resetInitial,
    input wire logic paddleMove,
    input wire logic left,
    input wire logic right,
    output logic [breakoutPkg::XW-1:0] paddleX,
    output logic [breakoutPkg::XW-1:0] oldPaddleX
);

    logic stepLeft;
    logic stepRight;

    // pressing both buttons cancels out
    assign stepLeft = left && !right;
    assign stepRight = right && !left;

    always_ff @(posedge clk)
    begin
        if (ld_resetInitial)
        begin
            paddleX <= breakoutPkg::PaddleXInit;
            oldPaddleX <= breakoutPkg::PaddleXInit;
        end
        else if (paddleMove)
        begin
            oldPaddleX <= paddleX;
            if (stepRight)
            begin
                if (paddleX >= breakoutPkg::PaddleXMax - breakoutPkg::PaddleStep)
                begin
                    paddleX <= breakoutPkg::PaddleXMax;
                end
                else
                begin
                    paddleX <= paddleX + breakoutPkg::PaddleStep;
                end
            end
            else if (stepLeft)
            begin
                // stop at the left edge rather than wrap
                if (paddleX < breakoutPkg::PaddleStep)
                begin
                    paddleX <= '0;
                end
                else
                begin
                    paddleX <= paddleX - breakoutPkg::PaddleStep;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- brickTable.sv
`timescale 1ns/1ps
`default_nettype none

module brickTable (
    input wire logic clk,
    input wire logic ld_resetInitial,
    input wire logic brickClear,
    input wire logic [breakoutPkg::BrickIdxW-1:0] brickIdx,
    output logic [breakoutPkg::XW-1:0] brickOriginX,
    output logic [breakoutPkg::YW-1:0] brickOriginY,
    output logic [breakoutPkg::ColourW-1:0] brickColour,
    output logic [breakoutPkg::NumBricks-1:0] brickAlive
);

    logic [1:0] colIdx;
    logic [breakoutPkg::BrickIdxW-3:0] rowIdx;

    // four bricks per row, so the low two bits pick the column
    assign colIdx = brickIdx[1:0];
    assign rowIdx = brickIdx[breakoutPkg::BrickIdxW-1:2];

    always_ff @(posedge clk)
    begin
        if (ld_resetInitial)
        begin
            brickAlive <= '1;
        end
        else if (brickClear && (brickIdx < breakoutPkg::NumBricks))
        begin
            brickAlive[brickIdx] <= 1'b0;
        end
    end

    always_comb
    begin
        brickOriginX = breakoutPkg::BrickX0[colIdx];
        brickOriginY = breakoutPkg::BrickY0[0];
        brickColour = breakoutPkg::ColourBlack;
        // indices past the last brick fall back to row 0 and black
        if (rowIdx < breakoutPkg::BrickRows)
        begin
            brickOriginY = breakoutPkg::BrickY0[rowIdx];
        end
        if (brickIdx < breakoutPkg::NumBricks)
        begin
            brickColour = breakoutPkg::BrickColour[brickIdx];
        end
    end

endmodule

`default_nettype wire

//--- breakoutPkg.sv
`default_nettype none

package breakoutPkg;

    // screen coordinates cover 640x480
    localparam int XW = 10;
    localparam int YW = 9;
    localparam int ColourW = 3;

    localparam int NumBricks = 12;
    localparam int BrickIdxW = 4;
    localparam int BrickCols = 4;
    localparam int BrickRows = 3;

    localparam logic [XW-1:0] ScreenW = 10'd640;

    localparam logic [XW-1:0] BrickW = 10'd120;
    localparam logic [YW-1:0] BrickH = 9'd40;

    // entry 0 is the leftmost column and the top row
    localparam logic [BrickCols-1:0][XW-1:0] BrickX0 = {10'd440, 10'd300, 10'd160, 10'd20};
    localparam logic [BrickRows-1:0][YW-1:0] BrickY0 = {9'd140, 9'd80, 9'd20};

    // brick 11 first, brick 0 last
    localparam logic [NumBricks-1:0][ColourW-1:0] BrickColour = {
        3'd5, 3'd3, 3'd5, 3'd5,
        3'd4, 3'd1, 3'd4, 3'd2,
        3'd2, 3'd4, 3'd5, 3'd4
    };

    localparam logic [XW-1:0] PaddleW = 10'd80;
    localparam logic [YW-1:0] PaddleH = 9'd20;
    localparam logic [YW-1:0] PaddleY = 9'd440;
    localparam logic [XW-1:0] PaddleStep = 10'd8;
    localparam logic [XW-1:0] PaddleXMax = ScreenW - PaddleW;
    localparam logic [XW-1:0] PaddleXInit = 10'd280;

    localparam logic [ColourW-1:0] ColourBlack = 3'd0;
    localparam logic [ColourW-1:0] ColourPaddle = 3'd7;

    typedef enum logic [1:0] {
        opPopulate = 2'd0,
        opRemove = 2'd1,
        opMovePaddle = 2'd2,
        opRedrawPaddle = 2'd3
    } opcode_t;

endpackage

`default_nettype wire
